// ==== filelist.f ====
gat_pkg.sv
node_mem.sv
mem_arbiter.sv
fxp_div_pipe.sv
softmax_engine.sv
gat_softmax_top.sv
softmax_checker.sv
tb_gat_softmax.sv

// ==== fxp_div_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module fxp_div_pipe
  import gat_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        i_en,
  input  wire        i_valid,
  input  wire exp_t  i_dividend,
  input  wire sum_t  i_divisor,
  output logic       o_valid,
  output alpha_t     o_quotient
);

  // stage registers, index 0 is the first stage
  logic [DIV_REM_W-1:0] rem_q [DIV_LAT];
  sum_t                 dsr_q [DIV_LAT];
  alpha_t               quo_q [DIV_LAT];
  logic [DIV_LAT-1:0]   vld_q;

  // stage inputs
  logic [DIV_REM_W-1:0] stg_rem [DIV_LAT];
  sum_t                 stg_dsr [DIV_LAT];
  alpha_t               stg_quo [DIV_LAT];

  // trial subtraction per stage
  logic [DIV_REM_W-1:0] trial [DIV_LAT];
  logic [DIV_LAT-1:0]   take;

  always_comb begin
    // scale by 2^WOF so the quotient comes out with 11 fraction bits
    stg_rem[0] = DIV_REM_W'(i_dividend) << ALPHA_WOF;
    stg_dsr[0] = i_divisor;
    stg_quo[0] = '0;
    for (int s = 1; s < DIV_LAT; s++) begin
      stg_rem[s] = rem_q[s-1];
      stg_dsr[s] = dsr_q[s-1];
      stg_quo[s] = quo_q[s-1];
    end
  end

  // stage s decides quotient bit ALPHA_W-1-s, msb first
  always_comb begin
    for (int s = 0; s < DIV_LAT; s++) begin
      trial[s] = DIV_REM_W'(stg_dsr[s]) << (ALPHA_W - 1 - s);
      take[s]  = stg_rem[s] >= trial[s];
    end
  end

  always_ff @(posedge clk) begin
    if (i_en) begin
      for (int s = 0; s < DIV_LAT; s++) begin
        if (take[s]) begin
          rem_q[s] <= stg_rem[s] - trial[s];
        end else begin
          rem_q[s] <= stg_rem[s];
        end
        dsr_q[s] <= stg_dsr[s];
        quo_q[s] <= stg_quo[s] | (alpha_t'(take[s]) << (ALPHA_W - 1 - s));
      end
    end
  end

  // valid bits move in lockstep with the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (i_en) begin
      vld_q <= {vld_q[DIV_LAT-2:0], i_valid};
    end
  end

  // remainder is dropped, result truncates
  assign o_valid    = vld_q[DIV_LAT-1];
  assign o_quotient = quo_q[DIV_LAT-1];

endmodule

`default_nettype wire

// ==== gat_pkg.sv ====
`default_nettype none

package gat_pkg;

  // coefficient slots per target node, count needs room for 32 itself
  localparam int MAX_NODES = 32;
  localparam int NODE_W    = 6;

  // coefficient is the shift amount of the power-of-two exponential
  localparam int COEF_W = 5;
  typedef logic [COEF_W-1:0] coef_t;

  localparam int EXP_W = 32;
  typedef logic [EXP_W-1:0] exp_t;

  // up to 32 terms of at most 2^31
  localparam int SUM_W = 37;
  typedef logic [SUM_W-1:0] sum_t;

  // weight format u1.11
  localparam int ALPHA_WOI = 1;
  localparam int ALPHA_WOF = 11;
  localparam int ALPHA_W   = ALPHA_WOI + ALPHA_WOF;
  typedef logic [ALPHA_W-1:0] alpha_t;

  // scratchpad map
  localparam int ADDR_W = 6;
  typedef logic [ADDR_W-1:0] addr_t;
  localparam addr_t COEF_BASE  = addr_t'(0);
  localparam addr_t ALPHA_BASE = addr_t'(MAX_NODES);

  localparam int WORD_W = 12;
  typedef logic [WORD_W-1:0] word_t;

  // one divider stage per quotient bit
  localparam int DIV_LAT   = ALPHA_W;
  // holds the scaled dividend and the divisor shifted to the top quotient bit
  localparam int DIV_REM_W = SUM_W + ALPHA_W;

  typedef enum logic [1:0] {
    IDLE,
    SUM,
    DIVIDE,
    FINISH
  } engine_state_t;

endpackage

`default_nettype wire

// ==== gat_softmax_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module gat_softmax_top
  import gat_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              i_start,
  input  wire [NODE_W-1:0] i_num_nodes,
  output logic             o_busy,
  output logic             o_done,
  // host port
  input  wire              i_host_req,
  input  wire              i_host_we,
  input  wire addr_t       i_host_addr,
  input  wire word_t       i_host_wdata,
  output logic             o_host_gnt,
  output logic             o_host_rvalid,
  output word_t            o_host_rdata
);

  // engine to arbiter
  logic  eng_req;
  logic  eng_we;
  addr_t eng_addr;
  word_t eng_wdata;
  logic  eng_gnt;
  logic  eng_rvalid;

  // arbiter to scratchpad
  logic  mem_en;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  word_t mem_rdata;

  // engine and divider
  logic   div_en;
  logic   div_in_valid;
  exp_t   div_dividend;
  sum_t   div_divisor;
  logic   div_out_valid;
  alpha_t div_quotient;

  // read data is shared, each side qualifies it with its own rvalid
  assign o_host_rdata = mem_rdata;

  softmax_engine engine_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_start        (i_start),
    .i_num_nodes    (i_num_nodes),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_req          (eng_req),
    .o_we           (eng_we),
    .o_addr         (eng_addr),
    .o_wdata        (eng_wdata),
    .i_gnt          (eng_gnt),
    .i_rvalid       (eng_rvalid),
    .i_rdata        (mem_rdata),
    .o_div_en       (div_en),
    .o_div_valid    (div_in_valid),
    .o_div_dividend (div_dividend),
    .o_div_divisor  (div_divisor),
    .i_div_valid    (div_out_valid),
    .i_div_quotient (div_quotient)
  );

  fxp_div_pipe div_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_en       (div_en),
    .i_valid    (div_in_valid),
    .i_dividend (div_dividend),
    .i_divisor  (div_divisor),
    .o_valid    (div_out_valid),
    .o_quotient (div_quotient)
  );

  mem_arbiter arb_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_host_req    (i_host_req),
    .i_host_we     (i_host_we),
    .i_host_addr   (i_host_addr),
    .i_host_wdata  (i_host_wdata),
    .o_host_gnt    (o_host_gnt),
    .o_host_rvalid (o_host_rvalid),
    .i_eng_req     (eng_req),
    .i_eng_we      (eng_we),
    .i_eng_addr    (eng_addr),
    .i_eng_wdata   (eng_wdata),
    .o_eng_gnt     (eng_gnt),
    .o_eng_rvalid  (eng_rvalid),
    .o_mem_en      (mem_en),
    .o_mem_we      (mem_we),
    .o_mem_addr    (mem_addr),
    .o_mem_wdata   (mem_wdata)
  );

  node_mem mem_i (
    .clk     (clk),
    .i_we    (mem_we),
    .i_addr  (mem_addr),
    .i_wdata (mem_wdata),
    .i_en    (mem_en),
    .o_rdata (mem_rdata)
  );

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter
  import gat_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  // host side, fixed priority
  input  wire        i_host_req,
  input  wire        i_host_we,
  input  wire addr_t i_host_addr,
  input  wire word_t i_host_wdata,
  output logic       o_host_gnt,
  output logic       o_host_rvalid,
  // engine side
  input  wire        i_eng_req,
  input  wire        i_eng_we,
  input  wire addr_t i_eng_addr,
  input  wire word_t i_eng_wdata,
  output logic       o_eng_gnt,
  output logic       o_eng_rvalid,
  // scratchpad port
  output logic       o_mem_en,
  output logic       o_mem_we,
  output addr_t      o_mem_addr,
  output word_t      o_mem_wdata
);

  logic rd_pend_q;
  logic rd_host_q;

  assign o_host_gnt = i_host_req;
  // engine only gets the idle host cycles
  assign o_eng_gnt  = i_eng_req && !i_host_req;

  always_comb begin
    o_mem_en = i_host_req || i_eng_req;
    if (i_host_req) begin
      o_mem_we    = i_host_we;
      o_mem_addr  = i_host_addr;
      o_mem_wdata = i_host_wdata;
    end else begin
      o_mem_we    = i_eng_we;
      o_mem_addr  = i_eng_addr;
      o_mem_wdata = i_eng_wdata;
    end
  end

  // owner of the read in flight
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend_q <= 1'b0;
      rd_host_q <= 1'b0;
    end else begin
      rd_pend_q <= o_mem_en && !o_mem_we;
      rd_host_q <= i_host_req;
    end
  end

  assign o_host_rvalid = rd_pend_q && rd_host_q;
  assign o_eng_rvalid  = rd_pend_q && !rd_host_q;

endmodule

`default_nettype wire

// ==== node_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module node_mem
  import gat_pkg::*;
(
  input  wire        clk,
  input  wire        i_we,
  input  wire addr_t i_addr,
  input  wire word_t i_wdata,
  input  wire        i_en,
  output word_t      o_rdata
);

  // coefficients in the low half, weights in the high half
  word_t mem_q [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (i_en) begin
      if (i_we) begin
        mem_q[i_addr] <= i_wdata;
      end else begin
        // read data lands one cycle after the access
        o_rdata <= mem_q[i_addr];
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the softmax testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timescale 1ns/1ns -f filelist.f \
  --top-module tb_gat_softmax -o sim_gat_softmax

./obj_dir/sim_gat_softmax | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0

// ==== softmax_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module softmax_checker
  import gat_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        i_start,
  input  wire        i_busy,
  input  wire        i_done,
  input  wire        i_host_req,
  input  wire        i_host_we,
  input  wire addr_t i_host_addr,
  input  wire        i_host_gnt,
  input  wire        i_host_rvalid,
  input  wire word_t i_host_rdata,
  input  wire word_t i_shadow [2**ADDR_W],
  output int         o_mismatch_cnt,
  output int         o_proto_cnt
);

  logic  rd_pend;
  addr_t rd_addr;
  logic  busy_prev;
  logic  done_prev;
  logic  start_prev;

  task automatic flag_protocol_error(input string msg);
    $display("%s", msg);
    o_proto_cnt++;
  endtask

  // falling edge sampling, DUT registers settle on the rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      rd_pend        = 1'b0;
      rd_addr        = '0;
      busy_prev      = 1'b0;
      done_prev      = 1'b0;
      start_prev     = 1'b0;
      o_mismatch_cnt = 0;
      o_proto_cnt    = 0;
    end else begin
      // read granted last cycle returns now
      if (rd_pend) begin
        if (!i_host_rvalid) begin
          flag_protocol_error(
            $sformatf("host rvalid missing one cycle after read grant, addr 0x%02h", rd_addr));
        end else if (i_host_rdata !== i_shadow[rd_addr]) begin
          $display("Mismatch o_host_rdata addr=0x%02h expected=0x%03h actual=0x%03h",
                   rd_addr, i_shadow[rd_addr], i_host_rdata);
          o_mismatch_cnt++;
        end
      end else if (i_host_rvalid) begin
        flag_protocol_error("host rvalid without a granted read");
      end
      // host has fixed priority, so every request wins its cycle
      if (i_host_req && !i_host_gnt) begin
        flag_protocol_error("host request not granted in its cycle");
      end
      rd_pend = i_host_req && i_host_gnt && !i_host_we;
      rd_addr = i_host_addr;

      if (i_done && !i_busy) begin
        flag_protocol_error("o_done high while o_busy is low");
      end
      if (done_prev && i_done) begin
        flag_protocol_error("o_done longer than one cycle");
      end
      if (done_prev && i_busy) begin
        flag_protocol_error("o_busy still high after o_done");
      end
      if (i_busy && !busy_prev && !start_prev) begin
        flag_protocol_error("o_busy rose without an accepted start");
      end
      if (start_prev && !busy_prev && !i_busy) begin
        flag_protocol_error("start accepted but o_busy stayed low");
      end
      busy_prev  = i_busy;
      done_prev  = i_done;
      start_prev = i_start;
    end
  end

endmodule

`default_nettype wire

// ==== softmax_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

module softmax_engine
  import gat_pkg::*;
(
  input  wire              clk,
  input  wire              rst_n,
  input  wire              i_start,
  input  wire [NODE_W-1:0] i_num_nodes,
  output logic             o_busy,
  output logic             o_done,
  // scratchpad side
  output logic             o_req,
  output logic             o_we,
  output addr_t            o_addr,
  output word_t            o_wdata,
  input  wire              i_gnt,
  input  wire              i_rvalid,
  input  wire word_t       i_rdata,
  // divider side
  output logic             o_div_en,
  output logic             o_div_valid,
  output exp_t             o_div_dividend,
  output sum_t             o_div_divisor,
  input  wire              i_div_valid,
  input  wire alpha_t      i_div_quotient
);

  engine_state_t     state_q;
  logic [NODE_W-1:0] num_q;
  logic [NODE_W-1:0] rd_cnt_q;
  logic [NODE_W-1:0] wr_cnt_q;
  logic              rd_pend_q;
  sum_t              sum_q;
  coef_t             hold_q;
  logic              hold_vld_q;

  logic  in_pass;
  logic  rd_req;
  logic  wr_req;
  coef_t rd_coef;

  assign rd_coef = i_rdata[COEF_W-1:0];
  assign in_pass = (state_q == SUM) || (state_q == DIVIDE);

  // a finished quotient claims the port before the next read
  assign wr_req = i_div_valid;
  // one read outstanding, so the holding register is always free when data returns
  assign rd_req = in_pass && !rd_pend_q && (rd_cnt_q < num_q) && !wr_req;

  always_comb begin
    o_req   = wr_req || rd_req;
    o_we    = wr_req;
    o_wdata = word_t'(i_div_quotient);
    if (wr_req) begin
      o_addr = ALPHA_BASE + addr_t'(wr_cnt_q);
    end else begin
      o_addr = COEF_BASE + addr_t'(rd_cnt_q);
    end
  end

  // whole divider holds while its result waits for the port
  assign o_div_en       = !(i_div_valid && !i_gnt);
  assign o_div_valid    = hold_vld_q;
  assign o_div_dividend = exp_t'(1) << hold_q;
  assign o_div_divisor  = sum_q;

  assign o_busy = state_q != IDLE;
  assign o_done = state_q == FINISH;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= IDLE;
      num_q      <= '0;
      rd_cnt_q   <= '0;
      wr_cnt_q   <= '0;
      rd_pend_q  <= 1'b0;
      hold_vld_q <= 1'b0;
    end else begin
      if (rd_req && i_gnt) begin
        rd_cnt_q  <= rd_cnt_q + 1'b1;
        rd_pend_q <= 1'b1;
      end else if (i_rvalid) begin
        rd_pend_q <= 1'b0;
      end

      if (wr_req && i_gnt) begin
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end

      // reread coefficient waits here until the divider takes it
      if (state_q == DIVIDE && i_rvalid) begin
        hold_vld_q <= 1'b1;
      end else if (o_div_en) begin
        hold_vld_q <= 1'b0;
      end

      case (state_q)
        IDLE: begin
          if (i_start) begin
            num_q    <= i_num_nodes;
            rd_cnt_q <= '0;
            wr_cnt_q <= '0;
            state_q  <= (i_num_nodes == '0) ? FINISH : SUM;
          end
        end
        SUM: begin
          // last coefficient arrived, restart reads for the second pass
          if (i_rvalid && rd_cnt_q == num_q) begin
            rd_cnt_q <= '0;
            state_q  <= DIVIDE;
          end
        end
        DIVIDE: begin
          if (wr_req && i_gnt && wr_cnt_q == num_q - 1'b1) begin
            state_q <= FINISH;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // sum of exponentials, frozen during the divide pass
  always_ff @(posedge clk) begin
    if (state_q == IDLE && i_start) begin
      sum_q <= '0;
    end else if (state_q == SUM && i_rvalid) begin
      sum_q <= sum_q + sum_t'(exp_t'(1) << rd_coef);
    end
  end

  always_ff @(posedge clk) begin
    if (i_rvalid) begin
      hold_q <= rd_coef;
    end
  end

endmodule

`default_nettype wire

// ==== tb_gat_softmax.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_gat_softmax
  import gat_pkg::*;
();

  localparam int NUM_RANDOM = 20;
  // random runs plus the zero, single, seven and full directed runs
  localparam int NUM_RUNS   = NUM_RANDOM + 4;
  localparam int RUN_CYCLES = 3 * MAX_NODES + DIV_LAT + 200;
  localparam int MEM_WORDS  = 2**ADDR_W;
  localparam logic [31:0] SEED = 32'h0485_f2d0;

  logic              clk;
  logic              rst_n;
  logic              i_start;
  logic [NODE_W-1:0] i_num_nodes;
  logic              i_host_req;
  logic              i_host_we;
  addr_t             i_host_addr;
  word_t             i_host_wdata;
  logic              o_busy;
  logic              o_done;
  logic              o_host_gnt;
  logic              o_host_rvalid;
  word_t             o_host_rdata;

  // expected scratchpad contents
  word_t shadow [MEM_WORDS];
  int    mismatch_cnt;
  int    proto_cnt;
  int    tb_err_cnt;

  gat_softmax_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_start       (i_start),
    .i_num_nodes   (i_num_nodes),
    .o_busy        (o_busy),
    .o_done        (o_done),
    .i_host_req    (i_host_req),
    .i_host_we     (i_host_we),
    .i_host_addr   (i_host_addr),
    .i_host_wdata  (i_host_wdata),
    .o_host_gnt    (o_host_gnt),
    .o_host_rvalid (o_host_rvalid),
    .o_host_rdata  (o_host_rdata)
  );

  softmax_checker checker_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_start        (i_start),
    .i_busy         (o_busy),
    .i_done         (o_done),
    .i_host_req     (i_host_req),
    .i_host_we      (i_host_we),
    .i_host_addr    (i_host_addr),
    .i_host_gnt     (o_host_gnt),
    .i_host_rvalid  (o_host_rvalid),
    .i_host_rdata   (o_host_rdata),
    .i_shadow       (shadow),
    .o_mismatch_cnt (mismatch_cnt),
    .o_proto_cnt    (proto_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    repeat (NUM_RUNS * RUN_CYCLES) @(posedge clk);
    $display("timeout: done never arrived");
    $display("SIMULATION FAILED");
    $finish;
  end

  // floor(2^c_k * 2^11 / sum of 2^c_j) over the first n coefficients
  function automatic word_t expected_weight(input int k, input int n);
    logic [63:0] sum;
    logic [63:0] num;
    sum = '0;
    for (int j = 0; j < n; j++) begin
      sum = sum + (64'(1) << shadow[j][COEF_W-1:0]);
    end
    num = (64'(1) << shadow[k][COEF_W-1:0]) << ALPHA_WOF;
    return word_t'(num / sum);
  endfunction

  task automatic host_write(input addr_t addr, input word_t data);
    i_host_req   = 1'b1;
    i_host_we    = 1'b1;
    i_host_addr  = addr;
    i_host_wdata = data;
    do begin
      @(posedge clk);
    end while (!o_host_gnt);
    shadow[addr] = data;
    #1;
    i_host_req = 1'b0;
    i_host_we  = 1'b0;
  endtask

  task automatic host_read(input addr_t addr);
    i_host_req  = 1'b1;
    i_host_we   = 1'b0;
    i_host_addr = addr;
    do begin
      @(posedge clk);
    end while (!o_host_gnt);
    #1;
    i_host_req = 1'b0;
  endtask

  task automatic read_all_words();
    for (int a = 0; a < MEM_WORDS; a++) begin
      host_read(addr_t'(a));
    end
    // last rvalid still has to reach the checker
    repeat (2) @(posedge clk);
    #1;
  endtask

  // upper word bits are random, the engine must only use the low five
  task automatic load_coefs(input int n, input bit equal_coef);
    word_t data;
    coef_t c;
    c = coef_t'($urandom);
    for (int k = 0; k < n; k++) begin
      data = word_t'($urandom);
      if (equal_coef) begin
        data[COEF_W-1:0] = c;
      end
      host_write(COEF_BASE + addr_t'(k), data);
    end
  endtask

  task automatic run_engine(input int n, input bit equal_coef, input bit host_traffic);
    int cycles;
    i_start     = 1'b1;
    i_num_nodes = NODE_W'(n);
    @(posedge clk);
    #1;
    i_start = 1'b0;
    cycles  = 1;
    while (!o_done) begin
      if (cycles == 3) begin
        // second start while busy, must be dropped
        i_start     = 1'b1;
        i_num_nodes = NODE_W'(MAX_NODES + 1 - n);
      end
      if (host_traffic && (!i_host_req || o_host_gnt)) begin
        i_host_req  = ($urandom_range(2) == 0);
        i_host_we   = 1'b0;
        i_host_addr = COEF_BASE + addr_t'($urandom_range(MAX_NODES - 1));
      end
      @(posedge clk);
      #1;
      i_start = 1'b0;
      cycles++;
    end
    i_host_req = 1'b0;
    if (n == 0 && cycles != 1) begin
      $display("done came %0d cycles after a start with zero nodes, expected 1", cycles);
      tb_err_cnt++;
    end
    for (int k = 0; k < n; k++) begin
      if (equal_coef) begin
        shadow[ALPHA_BASE + addr_t'(k)] = word_t'((1 << ALPHA_WOF) / n);
      end else begin
        shadow[ALPHA_BASE + addr_t'(k)] = expected_weight(k, n);
      end
    end
    read_all_words();
  endtask

  initial begin
    int    n;
    addr_t addr;
    void'($urandom(SEED));
    tb_err_cnt   = 0;
    rst_n        = 1'b0;
    i_start      = 1'b0;
    i_num_nodes  = '0;
    i_host_req   = 1'b0;
    i_host_we    = 1'b0;
    i_host_addr  = '0;
    i_host_wdata = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // known contents everywhere before the first compare
    for (int a = 0; a < MEM_WORDS; a++) begin
      host_write(addr_t'(a), word_t'(a * 709) ^ 12'h9a3);
    end
    read_all_words();
    addr = addr_t'($urandom);
    host_write(addr, word_t'($urandom));
    host_read(addr);

    run_engine(0, 1'b0, 1'b0);
    load_coefs(1, 1'b1);
    run_engine(1, 1'b1, 1'b0);
    load_coefs(7, 1'b1);
    run_engine(7, 1'b1, 1'b1);
    load_coefs(MAX_NODES, 1'b1);
    run_engine(MAX_NODES, 1'b1, 1'b0);
    for (int r = 0; r < NUM_RANDOM; r++) begin
      n = $urandom_range(MAX_NODES, 1);
      load_coefs(n, 1'b0);
      run_engine(n, 1'b0, r[0]);
    end

    $display("errors: %0d data mismatches, %0d protocol, %0d testbench",
             mismatch_cnt, proto_cnt, tb_err_cnt);
    if (mismatch_cnt + proto_cnt + tb_err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
